/* src/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// --------------------------------------------------
// Memory map, segment is address bits 31:28
// --------------------------------------------------

// Tightly-coupled memory
`define SEG_TCM 4'h0

// Uncached device window
`define SEG_DEV 4'hC

// System devices
`define SEG_SYS 4'hF

// Sub-select of the system segment, address bits 19:16
`define SYSDEV_CLINT 4'h0

// --------------------------------------------------
// TCM size
// --------------------------------------------------

// Depth in 32-bit words
`define TCM_WORDS 1024

// --------------------------------------------------
// Interrupt unit register map, word index is address bits 4:2
// --------------------------------------------------

`define CLINT_MSIP        3'd0
`define CLINT_MTIMECMP_LO 3'd2
`define CLINT_MTIMECMP_HI 3'd3
`define CLINT_MTIME_LO    3'd4
`define CLINT_MTIME_HI    3'd5

`endif

/* src/soc_pkg.sv */
`default_nettype none

// Types shared by the uncore blocks
package soc_pkg;

    // --------------------------------------------------
    // Bus words
    // --------------------------------------------------

    // Data or address word on every port
    typedef logic [31:0] word_t;

    // One enable bit per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // --------------------------------------------------
    // Data-side targets
    // --------------------------------------------------

    // Where a data access lands, picked from the top address nibble
    typedef enum logic [1:0] {
        TGT_TCM = 2'd0,
        TGT_MEM = 2'd1,
        TGT_DEV = 2'd2,
        TGT_SYS = 2'd3
    } target_e;

endpackage

`default_nettype wire

/* src/tcm_dp.sv */
`default_nettype none
`timescale 1ns/1ps
`include "soc_defs.svh"

module tcm_dp import soc_pkg::*; #(
    parameter int N_ENTRIES = `TCM_WORDS
) (
    input  wire logic     clk_i,
    // Fetch side, read only
    input  wire logic     code_en_i,
    input  wire word_t    code_idx_i,
    output word_t         code_o,
    output logic          code_ready_o,
    // Load and store side
    input  wire logic     data_en_i,
    input  wire logic     data_we_i,
    input  wire byte_en_t data_be_i,
    input  wire word_t    data_idx_i,
    input  wire word_t    data_i,
    output word_t         data_o,
    output logic          data_ready_o
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    word_t            mem [N_ENTRIES];
    logic [IDX_W-1:0] code_a, data_a;

    // Only the low index bits select a word
    assign code_a = code_idx_i[IDX_W-1:0];
    assign data_a = data_idx_i[IDX_W-1:0];

    // --------------------------------------------------
    // Code port
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (code_en_i) begin
            code_o <= mem[code_a];
        end
        code_ready_o <= code_en_i;
    end

    // --------------------------------------------------
    // Data port
    // --------------------------------------------------

    // Read returns the old word, writes touch enabled lanes only
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            data_o <= mem[data_a];
            if (data_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) begin
                        mem[data_a][b*8 +: 8] <= data_i[b*8 +: 8];
                    end
                end
            end
        end
        data_ready_o <= data_en_i;
    end

endmodule

`default_nettype wire

/* src/clint.sv */
`default_nettype none
`timescale 1ns/1ps
`include "soc_defs.svh"

module clint import soc_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // Register access from the router
    input  wire logic       en_i,
    input  wire logic       we_i,
    input  wire logic [2:0] idx_i,
    input  wire word_t      data_i,
    output word_t           data_o,
    output logic            ready_o,
    // Interrupt lines
    output logic            tmr_irq_o,
    output logic            sft_irq_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        msip;
    word_t       rd_word;

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------

    // mtime free-runs, software cannot load it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime    <= '0;
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (en_i && we_i) begin
                case (idx_i)
                    `CLINT_MSIP:        msip <= data_i[0];
                    `CLINT_MTIMECMP_LO: mtimecmp[31:0] <= data_i;
                    `CLINT_MTIMECMP_HI: mtimecmp[63:32] <= data_i;
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------

    // Holes in the map read as zero
    always_comb begin
        case (idx_i)
            `CLINT_MSIP:        rd_word = {31'd0, msip};
            `CLINT_MTIMECMP_LO: rd_word = mtimecmp[31:0];
            `CLINT_MTIMECMP_HI: rd_word = mtimecmp[63:32];
            `CLINT_MTIME_LO:    rd_word = mtime[31:0];
            `CLINT_MTIME_HI:    rd_word = mtime[63:32];
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            data_o <= rd_word;
        end
    end

    // One-cycle access latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= en_i;
        end
    end

    // --------------------------------------------------
    // Interrupts
    // --------------------------------------------------

    // Timer fires once mtime catches up with the compare value
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tmr_irq_o <= 1'b0;
        end else begin
            tmr_irq_o <= (mtime >= mtimecmp);
        end
    end

    assign sft_irq_o = msip;

endmodule

`default_nettype wire

/* src/mem_map_router.sv */
`default_nettype none
`timescale 1ns/1ps
`include "soc_defs.svh"

module mem_map_router import soc_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    // Core side
    input  wire logic     code_req_i,
    input  wire word_t    code_addr_i,
    output logic          code_ready_o,
    output word_t         code_o,
    input  wire logic     data_req_i,
    input  wire word_t    data_addr_i,
    input  wire logic     data_rw_i,
    input  wire byte_en_t data_be_i,
    input  wire word_t    data_wdata_i,
    output logic          data_ready_o,
    output word_t         data_rdata_o,
    // External ports
    output logic          imem_strobe_o,
    output word_t         imem_addr_o,
    input  wire logic     imem_ready_i,
    input  wire word_t    imem_data_i,
    output logic          dmem_strobe_o,
    output word_t         dmem_addr_o,
    output logic          dmem_rw_o,
    output byte_en_t      dmem_be_o,
    output word_t         dmem_wdata_o,
    input  wire logic     dmem_ready_i,
    input  wire word_t    dmem_rdata_i,
    output logic          dev_strobe_o,
    output word_t         dev_addr_o,
    output logic          dev_rw_o,
    output byte_en_t      dev_be_o,
    output word_t         dev_wdata_o,
    input  wire logic     dev_ready_i,
    input  wire word_t    dev_rdata_i,
    // TCM and interrupt unit
    output logic          tcm_code_en_o,
    output word_t         tcm_code_idx_o,
    input  wire word_t    tcm_code_i,
    input  wire logic     tcm_code_ready_i,
    output logic          tcm_data_en_o,
    output logic          tcm_data_we_o,
    output word_t         tcm_data_idx_o,
    input  wire word_t    tcm_data_i,
    input  wire logic     tcm_data_ready_i,
    output logic          clint_en_o,
    output logic          clint_we_o,
    output logic [2:0]    clint_idx_o,
    input  wire word_t    clint_data_i,
    input  wire logic     clint_ready_i
);

    target_e data_tgt, data_tgt_r;
    logic    code_is_tcm, code_tcm_r, sys_hit, clint_hit, fake_stb_r;
    logic    dmem_ready_r, dev_ready_r, imem_ready_r;
    word_t   dmem_rdata_r, dev_rdata_r, imem_data_r;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------

    assign code_is_tcm = (code_addr_i[31:28] == `SEG_TCM);

    always_comb begin
        case (data_addr_i[31:28])
            `SEG_TCM: data_tgt = TGT_TCM;
            `SEG_DEV: data_tgt = TGT_DEV;
            `SEG_SYS: data_tgt = TGT_SYS;
            default:  data_tgt = TGT_MEM;
        endcase
    end

    // System segment splits on bits 19:16
    assign sys_hit   = (data_tgt == TGT_SYS);
    assign clint_hit = sys_hit && (data_addr_i[19:16] == `SYSDEV_CLINT);

    // --------------------------------------------------
    // Request steering
    // --------------------------------------------------

    // Code side, word index keeps the segment aliased inside the TCM
    assign tcm_code_en_o  = code_req_i && code_is_tcm;
    assign tcm_code_idx_o = {2'b00, code_addr_i[31:2]};
    assign imem_strobe_o  = code_req_i && !code_is_tcm;
    assign imem_addr_o    = code_addr_i;

    // Data side, one strobe per target
    assign tcm_data_en_o  = data_req_i && (data_tgt == TGT_TCM);
    assign tcm_data_we_o  = data_rw_i && (data_tgt == TGT_TCM);
    assign tcm_data_idx_o = {2'b00, data_addr_i[31:2]};
    assign dmem_strobe_o  = data_req_i && (data_tgt == TGT_MEM);
    assign dmem_addr_o    = data_addr_i;
    assign dmem_rw_o      = data_rw_i;
    assign dmem_be_o      = data_be_i;
    assign dmem_wdata_o   = data_wdata_i;
    assign clint_en_o     = data_req_i && clint_hit;
    assign clint_we_o     = data_rw_i && clint_hit;
    assign clint_idx_o    = data_addr_i[4:2];

    // Device window shows nothing outside its own segment
    assign dev_strobe_o = data_req_i && (data_tgt == TGT_DEV);
    assign dev_rw_o     = data_rw_i && (data_tgt == TGT_DEV);
    assign dev_be_o     = data_be_i;
    assign dev_addr_o   = (data_tgt == TGT_DEV) ? data_addr_i : '0;
    assign dev_wdata_o  = (data_tgt == TGT_DEV) ? data_wdata_i : '0;

    // --------------------------------------------------
    // Registered targets and external replies
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_tgt_r   <= TGT_MEM;
            code_tcm_r   <= 1'b0;
            fake_stb_r   <= 1'b0;
            dmem_ready_r <= 1'b0;
            dev_ready_r  <= 1'b0;
            imem_ready_r <= 1'b0;
        end else begin
            data_tgt_r   <= data_tgt;
            code_tcm_r   <= code_is_tcm;
            // Anything off the CLINT sub-select answers next cycle
            fake_stb_r   <= data_req_i && sys_hit && !clint_hit;
            dmem_ready_r <= dmem_ready_i;
            dev_ready_r  <= dev_ready_i;
            imem_ready_r <= imem_ready_i;
        end
    end

    // Reply data follows its ready by the same cycle
    always_ff @(posedge clk_i) begin
        dmem_rdata_r <= dmem_rdata_i;
        dev_rdata_r  <= dev_rdata_i;
        imem_data_r  <= imem_data_i;
    end

    // --------------------------------------------------
    // Response mux
    // --------------------------------------------------

    always_comb begin
        case (data_tgt_r)
            TGT_TCM: begin
                data_ready_o = tcm_data_ready_i;
                data_rdata_o = tcm_data_i;
            end
            TGT_MEM: begin
                data_ready_o = dmem_ready_r;
                data_rdata_o = dmem_rdata_r;
            end
            TGT_DEV: begin
                data_ready_o = dev_ready_r;
                data_rdata_o = dev_rdata_r;
            end
            default: begin
                data_ready_o = clint_ready_i || fake_stb_r;
                data_rdata_o = fake_stb_r ? '0 : clint_data_i;
            end
        endcase
    end

    assign code_ready_o = code_tcm_r ? tcm_code_ready_i : imem_ready_r;
    assign code_o       = code_tcm_r ? tcm_code_i : imem_data_r;

endmodule

`default_nettype wire

/* src/soc_uncore_top.sv */
`default_nettype none
`timescale 1ns/1ps

module soc_uncore_top import soc_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,

    // Core code port
    input  wire logic     code_req_i,
    input  wire word_t    code_addr_i,
    output logic          code_ready_o,
    output word_t         code_o,

    // Core data port
    input  wire logic     data_req_i,
    input  wire word_t    data_addr_i,
    input  wire logic     data_rw_i,
    input  wire byte_en_t data_be_i,
    input  wire word_t    data_wdata_i,
    output logic          data_ready_o,
    output word_t         data_rdata_o,

    // External instruction memory
    output logic          imem_strobe_o,
    output word_t         imem_addr_o,
    input  wire logic     imem_ready_i,
    input  wire word_t    imem_data_i,

    // External main data memory
    output logic          dmem_strobe_o,
    output word_t         dmem_addr_o,
    output logic          dmem_rw_o,
    output byte_en_t      dmem_be_o,
    output word_t         dmem_wdata_o,
    input  wire logic     dmem_ready_i,
    input  wire word_t    dmem_rdata_i,

    // Uncached device port
    output logic          dev_strobe_o,
    output word_t         dev_addr_o,
    output logic          dev_rw_o,
    output byte_en_t      dev_be_o,
    output word_t         dev_wdata_o,
    input  wire logic     dev_ready_i,
    input  wire word_t    dev_rdata_i,

    // Interrupt lines toward the core
    output logic          tmr_irq_o,
    output logic          sft_irq_o
);

    // --------------------------------------------------
    // Router to TCM and interrupt unit
    // --------------------------------------------------

    logic       tcm_code_en;
    word_t      tcm_code_idx;
    word_t      tcm_code;
    logic       tcm_code_ready;
    logic       tcm_data_en;
    logic       tcm_data_we;
    word_t      tcm_data_idx;
    word_t      tcm_data;
    logic       tcm_data_ready;
    logic       clint_en;
    logic       clint_we;
    logic [2:0] clint_idx;
    word_t      clint_data;
    logic       clint_ready;

    // Address decode and response steering
    mem_map_router u_router (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .code_req_i       (code_req_i),
        .code_addr_i      (code_addr_i),
        .code_ready_o     (code_ready_o),
        .code_o           (code_o),
        .data_req_i       (data_req_i),
        .data_addr_i      (data_addr_i),
        .data_rw_i        (data_rw_i),
        .data_be_i        (data_be_i),
        .data_wdata_i     (data_wdata_i),
        .data_ready_o     (data_ready_o),
        .data_rdata_o     (data_rdata_o),
        .imem_strobe_o    (imem_strobe_o),
        .imem_addr_o      (imem_addr_o),
        .imem_ready_i     (imem_ready_i),
        .imem_data_i      (imem_data_i),
        .dmem_strobe_o    (dmem_strobe_o),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_rw_o        (dmem_rw_o),
        .dmem_be_o        (dmem_be_o),
        .dmem_wdata_o     (dmem_wdata_o),
        .dmem_ready_i     (dmem_ready_i),
        .dmem_rdata_i     (dmem_rdata_i),
        .dev_strobe_o     (dev_strobe_o),
        .dev_addr_o       (dev_addr_o),
        .dev_rw_o         (dev_rw_o),
        .dev_be_o         (dev_be_o),
        .dev_wdata_o      (dev_wdata_o),
        .dev_ready_i      (dev_ready_i),
        .dev_rdata_i      (dev_rdata_i),
        .tcm_code_en_o    (tcm_code_en),
        .tcm_code_idx_o   (tcm_code_idx),
        .tcm_code_i       (tcm_code),
        .tcm_code_ready_i (tcm_code_ready),
        .tcm_data_en_o    (tcm_data_en),
        .tcm_data_we_o    (tcm_data_we),
        .tcm_data_idx_o   (tcm_data_idx),
        .tcm_data_i       (tcm_data),
        .tcm_data_ready_i (tcm_data_ready),
        .clint_en_o       (clint_en),
        .clint_we_o       (clint_we),
        .clint_idx_o      (clint_idx),
        .clint_data_i     (clint_data),
        .clint_ready_i    (clint_ready)
    );

    // Segment 0, code on one port and data on the other
    tcm_dp u_tcm (
        .clk_i        (clk_i),
        .code_en_i    (tcm_code_en),
        .code_idx_i   (tcm_code_idx),
        .code_o       (tcm_code),
        .code_ready_o (tcm_code_ready),
        .data_en_i    (tcm_data_en),
        .data_we_i    (tcm_data_we),
        .data_be_i    (data_be_i),
        .data_idx_i   (tcm_data_idx),
        .data_i       (data_wdata_i),
        .data_o       (tcm_data),
        .data_ready_o (tcm_data_ready)
    );

    // Timer and software interrupt source
    clint u_clint (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (clint_en),
        .we_i      (clint_we),
        .idx_i     (clint_idx),
        .data_i    (data_wdata_i),
        .data_o    (clint_data),
        .ready_o   (clint_ready),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

`default_nettype wire

/* bench/soc_uncore_props.sv */
`default_nettype none
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_uncore_props import soc_pkg::*; (
    input wire logic  clk_i,
    input wire logic  rst_n_i,
    input wire word_t data_addr_i,
    input wire logic  tcm_code_en_i,
    input wire logic  tcm_code_ready_i,
    input wire logic  tcm_data_en_i,
    input wire logic  tcm_data_ready_i,
    input wire logic  dmem_strobe_i,
    input wire logic  dev_strobe_i,
    input wire logic  clint_en_i,
    input wire word_t dev_addr_i
);

    // --------------------------------------------------
    // Data-side strobes
    // --------------------------------------------------

    // A data request lands on one target at most
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({tcm_data_en_i, dmem_strobe_i, dev_strobe_i, clint_en_i}))
        else $error("more than one data-side strobe high");

    // Device address bus stays quiet outside its segment
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_addr_i[31:28] != `SEG_DEV) |-> (dev_addr_i == '0))
        else $error("device address driven outside the device segment");

    // --------------------------------------------------
    // TCM latency
    // --------------------------------------------------

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tcm_code_en_i |=> tcm_code_ready_i)
        else $error("TCM code ready missing one cycle after enable");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tcm_data_en_i |=> tcm_data_ready_i)
        else $error("TCM data ready missing one cycle after enable");

endmodule

// Attach to every router instance
bind mem_map_router soc_uncore_props u_props (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .data_addr_i      (data_addr_i),
    .tcm_code_en_i    (tcm_code_en_o),
    .tcm_code_ready_i (tcm_code_ready_i),
    .tcm_data_en_i    (tcm_data_en_o),
    .tcm_data_ready_i (tcm_data_ready_i),
    .dmem_strobe_i    (dmem_strobe_o),
    .dev_strobe_i     (dev_strobe_o),
    .clint_en_i       (clint_en_o),
    .dev_addr_i       (dev_addr_o)
);

`default_nettype wire

/* bench/tb_soc_uncore_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_uncore_top import soc_pkg::*; ();

    localparam int N_TCM   = 200;
    localparam int N_MEM   = 100;
    localparam int N_DEV   = 60;
    localparam int N_FETCH = 80;
    localparam int N_FAKE  = 20;
    // Init writes, interrupt-unit accesses and the random phases
    localparam int N_TXN   = 64 + 16 + N_TCM + N_MEM + N_DEV + N_FETCH + N_FAKE;

    logic clk_i, rst_n_i;
    logic code_req_i, code_ready_o;
    word_t code_addr_i, code_o;
    logic data_req_i, data_rw_i, data_ready_o;
    word_t data_addr_i, data_wdata_i, data_rdata_o;
    byte_en_t data_be_i;
    logic imem_strobe_o, imem_ready_i;
    word_t imem_addr_o, imem_data_i;
    logic dmem_strobe_o, dmem_rw_o, dmem_ready_i;
    word_t dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    byte_en_t dmem_be_o;
    logic dev_strobe_o, dev_rw_o, dev_ready_i;
    word_t dev_addr_o, dev_wdata_o, dev_rdata_i;
    byte_en_t dev_be_o;
    logic tmr_irq_o, sft_irq_o;

    integer seed;
    logic [7:0] tcm_ref [64][4];
    word_t dmem_arr [word_t];

    soc_uncore_top u_soc_uncore_top (.*);

    // --------------------------------------------------
    // Clock, watchdog and helpers
    // --------------------------------------------------

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        repeat (16 + N_TXN * 20) @(posedge clk_i);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "check failed");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // Default contents of unwritten main memory, every address bit counts
    function automatic word_t fill_word(input word_t a);
        return {a[15:0], a[31:16]} ^ 32'h1357_9bdf ^ {a[7:0], 24'h0};
    endfunction

    function automatic word_t dev_word(input word_t a);
        return ~a ^ 32'h0f0f_1234;
    endfunction

    function automatic word_t code_word(input word_t a);
        return (a * 32'h9e37_79b9) ^ 32'h5555_aaaa;
    endfunction

    function automatic word_t dmem_peek(input word_t a);
        return dmem_arr.exists(a) ? dmem_arr[a] : fill_word(a);
    endfunction

    function automatic word_t ref_word(input int idx);
        return {tcm_ref[idx][3], tcm_ref[idx][2], tcm_ref[idx][1], tcm_ref[idx][0]};
    endfunction

    // Upper bits vary, the TCM index sits in bits 7:2
    function automatic word_t tcm_addr(input int idx, input word_t r);
        return {4'h0, r[27:12], 4'h0, idx[5:0], 2'b00};
    endfunction

    function automatic word_t clint_addr(input logic [2:0] idx, input word_t r);
        return {`SEG_SYS, r[11:4], `SYSDEV_CLINT, 11'h0, idx, 2'b00};
    endfunction

    // --------------------------------------------------
    // External slave models
    // --------------------------------------------------

    initial begin : dmem_model
        int    lat;
        word_t key;
        word_t w;
        forever begin
            @(negedge clk_i);
            if (dmem_strobe_o) begin
                key = {dmem_addr_o[31:2], 2'b00};
                w = dmem_peek(key);
                if (dmem_rw_o) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_be_o[b]) w[b*8 +: 8] = dmem_wdata_o[b*8 +: 8];
                    end
                    dmem_arr[key] = w;
                end
                lat = $random(seed) & 3;
                repeat (lat + 1) @(posedge clk_i);
                dmem_ready_i <= 1'b1;
                dmem_rdata_i <= w;
                @(posedge clk_i);
                dmem_ready_i <= 1'b0;
                dmem_rdata_i <= '0;
            end
        end
    end

    initial begin : dev_model
        int    lat;
        word_t w;
        forever begin
            @(negedge clk_i);
            if (dev_strobe_o) begin
                w = dev_word(dev_addr_o);
                lat = $random(seed) & 3;
                repeat (lat + 1) @(posedge clk_i);
                dev_ready_i <= 1'b1;
                dev_rdata_i <= w;
                @(posedge clk_i);
                dev_ready_i <= 1'b0;
                dev_rdata_i <= '0;
            end
        end
    end

    initial begin : imem_model
        int    lat;
        word_t w;
        forever begin
            @(negedge clk_i);
            if (imem_strobe_o) begin
                w = code_word(imem_addr_o);
                lat = $random(seed) & 3;
                repeat (lat + 1) @(posedge clk_i);
                imem_ready_i <= 1'b1;
                imem_data_i  <= w;
                @(posedge clk_i);
                imem_ready_i <= 1'b0;
                imem_data_i  <= '0;
            end
        end
    end

    // --------------------------------------------------
    // Core-side drivers
    // --------------------------------------------------

    // One data access, strobe checks in the request cycle, then wait for ready
    task automatic data_access(input word_t addr, input logic rw, input byte_en_t be,
                               input word_t wdata, output word_t rdata, output int waits);
        logic [3:0] seg;
        seg = addr[31:28];
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_addr_i  <= addr;
        data_rw_i    <= rw;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        check("imem_strobe_o", imem_strobe_o, 0);
        check("dev_strobe_o", dev_strobe_o, seg == `SEG_DEV);
        check("dmem_strobe_o", dmem_strobe_o,
              seg != `SEG_TCM && seg != `SEG_DEV && seg != `SEG_SYS);
        if (seg == `SEG_DEV) begin
            check("dev_addr_o", dev_addr_o, addr);
            check("dev_rw_o", dev_rw_o, rw);
            check("dev_be_o", dev_be_o, be);
            check("dev_wdata_o", dev_wdata_o, wdata);
        end else begin
            check("dev_addr_o", dev_addr_o, 0);
            check("dev_wdata_o", dev_wdata_o, 0);
        end
        if (dmem_strobe_o) begin
            check("dmem_addr_o", dmem_addr_o, addr);
            check("dmem_rw_o", dmem_rw_o, rw);
            check("dmem_be_o", dmem_be_o, be);
            check("dmem_wdata_o", dmem_wdata_o, wdata);
        end
        @(posedge clk_i);
        data_req_i <= 1'b0;
        waits = 0;
        forever begin
            @(negedge clk_i);
            if (data_ready_o) break;
            waits++;
            if (waits > 12) fail_run("Data access received no ready");
        end
        rdata = data_rdata_o;
    endtask

    task automatic fetch(input word_t addr, output word_t insn);
        int waits;
        @(posedge clk_i);
        code_req_i  <= 1'b1;
        code_addr_i <= addr;
        @(negedge clk_i);
        check("imem_strobe_o", imem_strobe_o, addr[31:28] != `SEG_TCM);
        check("dmem_strobe_o", dmem_strobe_o, 0);
        if (imem_strobe_o) check("imem_addr_o", imem_addr_o, addr);
        @(posedge clk_i);
        code_req_i <= 1'b0;
        waits = 0;
        forever begin
            @(negedge clk_i);
            if (code_ready_o) break;
            waits++;
            if (waits > 12) fail_run("Instruction fetch received no ready");
        end
        insn = code_o;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        word_t w, rd, a;
        int    idx, op, waits;
        logic [3:0] sub;
        seed = 32'hc4e3_7fde;
        rst_n_i = 1'b0;
        code_req_i = 1'b0;
        code_addr_i = '0;
        data_req_i = 1'b0;
        data_addr_i = '0;
        data_rw_i = 1'b0;
        data_be_i = '0;
        data_wdata_i = '0;
        imem_ready_i = 1'b0;
        imem_data_i = '0;
        dmem_ready_i = 1'b0;
        dmem_rdata_i = '0;
        dev_ready_i = 1'b0;
        dev_rdata_i = '0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // TCM: fill the test window, then mixed byte writes, loads and fetches
        for (int i = 0; i < 64; i++) begin
            w = $random(seed);
            data_access(tcm_addr(i, $random(seed)), 1'b1, 4'hf, w, rd, waits);
            for (int b = 0; b < 4; b++) tcm_ref[i][b] = w[b*8 +: 8];
        end
        for (int i = 0; i < N_TCM; i++) begin
            idx = $random(seed) & 63;
            op = $random(seed) & 3;
            a = tcm_addr(idx, $random(seed));
            if (op < 2) begin
                w = $random(seed);
                data_access(a, 1'b1, byte_en_t'($random(seed)), w, rd, waits);
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) tcm_ref[idx][b] = w[b*8 +: 8];
                end
            end else if (op == 2) begin
                data_access(a, 1'b0, 4'hf, '0, rd, waits);
                check("data_rdata_o", rd, ref_word(idx));
            end else begin
                fetch(a, rd);
                check("code_o", rd, ref_word(idx));
            end
        end

        // Main memory over a small window so reads revisit writes
        for (int i = 0; i < N_MEM; i++) begin
            w = $random(seed);
            a = {4'h1 + 4'(w[30:28]), 22'h0, w[3:0], 2'b00};
            if (w[31]) begin
                data_access(a, 1'b1, byte_en_t'($random(seed)), $random(seed), rd, waits);
            end else begin
                w = dmem_peek(a);
                data_access(a, 1'b0, 4'hf, '0, rd, waits);
                check("data_rdata_o", rd, w);
            end
        end

        // Device window
        for (int i = 0; i < N_DEV; i++) begin
            w = $random(seed);
            a = {`SEG_DEV, w[27:0]};
            if (w[0]) begin
                data_access(a, 1'b1, byte_en_t'($random(seed)), $random(seed), rd, waits);
            end else begin
                data_access(a, 1'b0, 4'hf, '0, rd, waits);
                check("data_rdata_o", rd, dev_word(a));
            end
        end

        // External fetches, any segment but 0
        for (int i = 0; i < N_FETCH; i++) begin
            w = $random(seed);
            a = {(w[31:28] == 4'h0) ? 4'h1 : w[31:28], w[27:2], 2'b00};
            fetch(a, rd);
            check("code_o", rd, code_word(a));
        end

        // Interrupt unit: compare readback
        w = $random(seed);
        data_access(clint_addr(`CLINT_MTIMECMP_LO, $random(seed)), 1'b1, 4'hf, w, rd, waits);
        data_access(clint_addr(`CLINT_MTIMECMP_LO, $random(seed)), 1'b0, 4'hf, '0, rd, waits);
        check("mtimecmp_lo", rd, w);
        w = $random(seed);
        data_access(clint_addr(`CLINT_MTIMECMP_HI, $random(seed)), 1'b1, 4'hf, w, rd, waits);
        data_access(clint_addr(`CLINT_MTIMECMP_HI, $random(seed)), 1'b0, 4'hf, '0, rd, waits);
        check("mtimecmp_hi", rd, w);
        data_access(clint_addr(3'd1, $random(seed)), 1'b0, 4'hf, '0, rd, waits);
        check("clint_hole", rd, 0);

        // Compare at all ones keeps the timer quiet
        data_access(clint_addr(`CLINT_MTIMECMP_LO, 0), 1'b1, 4'hf, '1, rd, waits);
        data_access(clint_addr(`CLINT_MTIMECMP_HI, 0), 1'b1, 4'hf, '1, rd, waits);
        repeat (6) begin
            @(negedge clk_i);
            check("tmr_irq_o", tmr_irq_o, 0);
        end

        // Software interrupt follows msip bit 0
        data_access(clint_addr(`CLINT_MSIP, 0), 1'b1, 4'hf, 32'h1, rd, waits);
        check("sft_irq_o", sft_irq_o, 1);
        data_access(clint_addr(`CLINT_MSIP, 0), 1'b0, 4'hf, '0, rd, waits);
        check("msip", rd, 1);
        data_access(clint_addr(`CLINT_MSIP, 0), 1'b1, 4'hf, 32'h0, rd, waits);
        check("sft_irq_o", sft_irq_o, 0);

        // Compare at zero, high half first so the timer only fires on the last write
        data_access(clint_addr(`CLINT_MTIMECMP_HI, 0), 1'b1, 4'hf, '0, rd, waits);
        check("tmr_irq_o", tmr_irq_o, 0);
        data_access(clint_addr(`CLINT_MTIMECMP_LO, 0), 1'b1, 4'hf, '0, rd, waits);
        waits = 0;
        while (!tmr_irq_o) begin
            @(negedge clk_i);
            waits++;
            if (waits > 2 && !tmr_irq_o) fail_run("Timer interrupt did not rise");
        end

        // Fake system region answers next cycle with zero
        for (int i = 0; i < N_FAKE; i++) begin
            w = $random(seed);
            sub = (w[19:16] == `SYSDEV_CLINT) ? 4'h1 : w[19:16];
            a = {`SEG_SYS, w[27:20], sub, w[15:0]};
            data_access(a, w[31], 4'hf, $random(seed), rd, waits);
            check("fake_wait", waits, 0);
            if (!w[31]) check("data_rdata_o", rd, 0);
        end

        // Timer stays pending while the compare is zero
        check("tmr_irq_o", tmr_irq_o, 1);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/soc_pkg.sv
src/tcm_dp.sv
src/clint.sv
src/mem_map_router.sv
src/soc_uncore_top.sv
bench/soc_uncore_props.sv
bench/tb_soc_uncore_top.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Mdir obj_dir \
    --top-module tb_soc_uncore_top -f build.f -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log

grep -qx "Regression passed" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
